// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := ironhorse_glue_tb
FILELIST  := ironhorse_glue.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/clock_enables.sv
// Clock enable generator with fixed dividers, 6809 E/Q phase strobes and sound enable select
`timescale 1ns/1ps
`default_nettype none

module clock_enables #(
	parameter int unsigned FRAC_N = 50,
	parameter int unsigned FRAC_M = 786
) (
	input  logic clk_49m,
	input  logic sirq_clr,
	input  logic underclock_i,
	output logic cen_3m_o,
	output logic cen_e_o,
	output logic cen_q_o,
	output logic cen_sound_o
);

	// ==============================
	// Fixed divider
	// ==============================

	// Free-running divider of the 49.152 MHz master clock
	logic [ironhorse_pkg::DIV_W-1:0] div;
	logic cen_6m;
	logic cen_frac;

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	// 6.144 MHz enable, one cycle in eight
	assign cen_6m = (div[2:0] == 3'd0);
	// 3.072 MHz enable, one cycle in sixteen
	assign cen_3m_o = (div[3:0] == 4'd0);

	// ==============================
	// 6809E phase sequencer
	// ==============================

	// Four 6 MHz steps make one CPU cycle, Q leads E by a quarter cycle
	logic [1:0] clk_phase;

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			clk_phase <= 2'd0;
			cen_q_o <= 1'b0;
			cen_e_o <= 1'b0;
		end else begin
			// Strobes are single cycle and land one clock after the 6 MHz enable
			cen_q_o <= cen_6m && (clk_phase == 2'd1);
			cen_e_o <= cen_6m && (clk_phase == 2'd2);
			if (cen_6m) begin
				clk_phase <= clk_phase + 2'd1;
			end
		end
	end

	// Fractional 3.072 MHz for the sound side when the board runs underclocked
	frac_cen #(
		.FRAC_N(FRAC_N),
		.FRAC_M(FRAC_M)
	) u_frac_cen (
		.clk_49m (clk_49m),
		.sirq_clr(sirq_clr),
		.cen_o   (cen_frac)
	);

	assign cen_sound_o = underclock_i ? cen_frac : cen_3m_o;

endmodule

`default_nettype wire

// File: hw/frac_cen.sv
// Fractional clock enable giving FRAC_N one-cycle pulses in every FRAC_M clocks
`timescale 1ns/1ps
`default_nettype none

module frac_cen #(
	parameter int unsigned FRAC_N = 50,
	parameter int unsigned FRAC_M = 786
) (
	input  logic clk_49m,
	input  logic sirq_clr,
	output logic cen_o
);

	localparam int W = ironhorse_pkg::FRAC_W;

	// Step and modulus carry one extra bit so the sum never wraps
	localparam logic [W:0] INC = FRAC_N[W:0];
	localparam logic [W:0] MOD = FRAC_M[W:0];

	// Accumulator stays below M, it holds the phase error of the pulse train
	logic [W-1:0] acc;
	logic [W:0]   acc_sum;
	logic [W:0]   acc_wrap;

	// Next value if no pulse is issued this cycle
	assign acc_sum = {1'b0, acc} + INC;
	// Next value after taking M back out
	assign acc_wrap = acc_sum - MOD;

	// A pulse is due whenever the running sum crosses M
	// Comparing the current state keeps the count exact from the first cycle out of reset
	assign cen_o = (acc_sum >= MOD);

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			acc <= '0;
		end else if (cen_o) begin
			acc <= acc_wrap[W-1:0];
		end else begin
			acc <= acc_sum[W-1:0];
		end
	end

	// Average rate is N/M of the clock exactly, so pitch holds when underclocked

endmodule

`default_nettype wire

// File: hw/ironhorse_glue.sv
// Iron Horse glue top level joining clock enables, main I/O decode and the sound CPU port
`timescale 1ns/1ps
`default_nettype none

module ironhorse_glue #(
	// 50 pulses per 786 clocks gives 3.072 MHz from the underclocked master
	parameter int unsigned FRAC_N = 50,
	parameter int unsigned FRAC_M = 786
) (
	input  logic                     clk_49m,
	input  logic                     sirq_clr,
	input  logic                     underclock_i,
	// Main 6809 bus
	input  ironhorse_pkg::cpu_addr_t main_addr_i,
	input  logic                     main_rw_i,
	input  logic                     main_ioc_n_i,
	input  ironhorse_pkg::cpu_data_t main_wdata_i,
	// Sound Z80 bus
	input  ironhorse_pkg::cpu_addr_t snd_addr_i,
	input  logic                     snd_mreq_n_i,
	input  logic                     snd_rfsh_n_i,
	input  logic                     snd_rd_n_i,
	input  logic                     snd_m1_n_i,
	input  logic                     snd_iorq_n_i,
	// Switches and player controls
	input  ironhorse_pkg::dipsw_t    dipsw_i,
	input  logic [1:0]               coin_i,
	input  logic [1:0]               btn_start_i,
	input  logic                     btn_service_i,
	input  logic [3:0]               p1_joystick_i,
	input  logic [3:0]               p2_joystick_i,
	input  logic [2:0]               p1_buttons_i,
	input  logic [2:0]               p2_buttons_i,
	output ironhorse_pkg::cpu_data_t main_rdata_o,
	output ironhorse_pkg::pal_bank_t pal_bank_o,
	output ironhorse_pkg::cpu_data_t snd_rdata_o,
	output logic                     snd_int_n_o,
	output logic                     cen_e_o,
	output logic                     cen_q_o,
	output logic                     cen_sound_o
);

	logic                     cen_3m;
	ironhorse_pkg::cpu_data_t sound_cmd;
	logic                     sound_irq_req;

	clock_enables #(
		.FRAC_N(FRAC_N),
		.FRAC_M(FRAC_M)
	) u_clock_enables (
		.clk_49m     (clk_49m),
		.sirq_clr    (sirq_clr),
		.underclock_i(underclock_i),
		.cen_3m_o    (cen_3m),
		.cen_e_o     (cen_e_o),
		.cen_q_o     (cen_q_o),
		.cen_sound_o (cen_sound_o)
	);

	main_io_decode u_main_io_decode (
		.clk_49m        (clk_49m),
		.sirq_clr       (sirq_clr),
		.cen_3m_i       (cen_3m),
		.main_addr_i    (main_addr_i),
		.main_rw_i      (main_rw_i),
		.main_ioc_n_i   (main_ioc_n_i),
		.main_wdata_i   (main_wdata_i),
		.dipsw_i        (dipsw_i),
		.coin_i         (coin_i),
		.btn_start_i    (btn_start_i),
		.btn_service_i  (btn_service_i),
		.p1_joystick_i  (p1_joystick_i),
		.p2_joystick_i  (p2_joystick_i),
		.p1_buttons_i   (p1_buttons_i),
		.p2_buttons_i   (p2_buttons_i),
		.main_rdata_o   (main_rdata_o),
		.pal_bank_o     (pal_bank_o),
		.sound_cmd_o    (sound_cmd),
		.sound_irq_req_o(sound_irq_req)
	);

	// Sound side runs on the selected sound enable, the same one the YM2203 used
	sound_cpu_port u_sound_cpu_port (
		.clk_49m        (clk_49m),
		.sirq_clr       (sirq_clr),
		.cen_sound_i    (cen_sound_o),
		.snd_addr_i     (snd_addr_i),
		.snd_mreq_n_i   (snd_mreq_n_i),
		.snd_rfsh_n_i   (snd_rfsh_n_i),
		.snd_rd_n_i     (snd_rd_n_i),
		.snd_m1_n_i     (snd_m1_n_i),
		.snd_iorq_n_i   (snd_iorq_n_i),
		.sound_cmd_i    (sound_cmd),
		.sound_irq_req_i(sound_irq_req),
		.snd_rdata_o    (snd_rdata_o),
		.snd_int_n_o    (snd_int_n_o)
	);

endmodule

`default_nettype wire

// File: hw/ironhorse_pkg.sv
// Iron Horse glue package holding bus widths, I/O region codes and shared constants
`default_nettype none

package ironhorse_pkg;

	// ==============================
	// Bus and field types
	// ==============================

	// Address bus of the main 6809 and of the sound Z80
	typedef logic [15:0] cpu_addr_t;
	// One data byte on either CPU bus
	typedef logic [7:0] cpu_data_t;
	// Three DIP switch banks, bank 1 in the low byte and bank 3 in the top byte
	typedef logic [23:0] dipsw_t;
	// Palette bank select, the upper colour PROM address bits
	typedef logic [2:0] pal_bank_t;
	// I/O sub-region taken from main address bits 10 to 8
	typedef logic [2:0] io_region_t;

	// ==============================
	// Main CPU I/O region map
	// ==============================

	localparam io_region_t IO_SOUNDLATCH = 3'd0;
	localparam io_region_t IO_DIP3_SIRQ = 3'd1;
	localparam io_region_t IO_DIP2_PAL = 3'd2;
	localparam io_region_t IO_CTRL_DIP1 = 3'd3;

	// Unmapped reads float high on the real board
	localparam cpu_data_t OPEN_BUS = 8'hFF;

	// Divider counter and fractional divider widths
	localparam int DIV_W = 7;
	localparam int FRAC_W = 10;

endpackage

`default_nettype wire

// File: hw/main_io_decode.sv
// Main CPU I/O decode with DIP and control read mux, palette latch, sound latch and IRQ trigger
`timescale 1ns/1ps
`default_nettype none

module main_io_decode (
	input  logic                     clk_49m,
	input  logic                     sirq_clr,
	input  logic                     cen_3m_i,
	input  ironhorse_pkg::cpu_addr_t main_addr_i,
	input  logic                     main_rw_i,
	input  logic                     main_ioc_n_i,
	input  ironhorse_pkg::cpu_data_t main_wdata_i,
	input  ironhorse_pkg::dipsw_t    dipsw_i,
	input  logic [1:0]               coin_i,
	input  logic [1:0]               btn_start_i,
	input  logic                     btn_service_i,
	input  logic [3:0]               p1_joystick_i,
	input  logic [3:0]               p2_joystick_i,
	input  logic [2:0]               p1_buttons_i,
	input  logic [2:0]               p2_buttons_i,
	output ironhorse_pkg::cpu_data_t main_rdata_o,
	output ironhorse_pkg::pal_bank_t pal_bank_o,
	output ironhorse_pkg::cpu_data_t sound_cmd_o,
	output logic                     sound_irq_req_o
);

	// ==============================
	// Region decode
	// ==============================

	ironhorse_pkg::io_region_t region;
	ironhorse_pkg::cpu_data_t  ctrl_dip1;
	logic io_rd;
	logic io_wr;

	// The video chip pulls IOC low for the whole I/O window
	assign region = main_addr_i[10:8];
	assign io_rd = ~main_ioc_n_i & main_rw_i;
	assign io_wr = ~main_ioc_n_i & ~main_rw_i;

	// Player inputs and DIP bank 1 share region 3, picked by the two low address bits
	always_comb begin
		case (main_addr_i[1:0])
			2'd0: ctrl_dip1 = dipsw_i[7:0];
			// P1 button 3 rides along with the player 2 port
			2'd1: ctrl_dip1 = {1'b1, p1_buttons_i[2], p2_buttons_i[1:0], p2_joystick_i};
			// And P2 button 3 rides along with the player 1 port
			2'd2: ctrl_dip1 = {1'b1, p2_buttons_i[2], p1_buttons_i[1:0], p1_joystick_i};
			default: ctrl_dip1 = {3'b111, btn_start_i, btn_service_i, coin_i};
		endcase
	end

	// ==============================
	// Read mux
	// ==============================

	// ROM and video reads are not modelled here so they fall through to open bus
	always_comb begin
		main_rdata_o = ironhorse_pkg::OPEN_BUS;
		if (io_rd) begin
			case (region)
				// Bank 3 is only four switches wide, the top nibble floats high
				ironhorse_pkg::IO_DIP3_SIRQ: main_rdata_o = {4'hF, dipsw_i[19:16]};
				ironhorse_pkg::IO_DIP2_PAL:  main_rdata_o = dipsw_i[15:8];
				ironhorse_pkg::IO_CTRL_DIP1: main_rdata_o = ctrl_dip1;
				default:                     main_rdata_o = ironhorse_pkg::OPEN_BUS;
			endcase
		end
	end

	// ==============================
	// Write latches
	// ==============================

	// All writes are sampled on the 3 MHz enable, as on the board
	// A CPU write held for a full E cycle is therefore always seen once
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			sound_cmd_o <= '0;
			pal_bank_o <= '0;
			sound_irq_req_o <= 1'b0;
		end else if (cen_3m_i) begin
			// Trigger is a level that follows the write, it drops at the next enable
			sound_irq_req_o <= io_wr && (region == ironhorse_pkg::IO_DIP3_SIRQ);
			if (io_wr && (region == ironhorse_pkg::IO_SOUNDLATCH)) begin
				sound_cmd_o <= main_wdata_i;
			end
			// Only three palette bank bits are wired to the colour PROMs
			if (io_wr && (region == ironhorse_pkg::IO_DIP2_PAL)) begin
				pal_bank_o <= main_wdata_i[2:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/sound_cpu_port.sv
// Sound CPU side port returning the command latch and holding the sound interrupt flag
`timescale 1ns/1ps
`default_nettype none

module sound_cpu_port (
	input  logic                     clk_49m,
	input  logic                     sirq_clr,
	input  logic                     cen_sound_i,
	input  ironhorse_pkg::cpu_addr_t snd_addr_i,
	input  logic                     snd_mreq_n_i,
	input  logic                     snd_rfsh_n_i,
	input  logic                     snd_rd_n_i,
	input  logic                     snd_m1_n_i,
	input  logic                     snd_iorq_n_i,
	input  ironhorse_pkg::cpu_data_t sound_cmd_i,
	input  logic                     sound_irq_req_i,
	output ironhorse_pkg::cpu_data_t snd_rdata_o,
	output logic                     snd_int_n_o
);

	// ==============================
	// Command latch read
	// ==============================

	// Latch sits in the 0x8000 to 0xBFFF page of the Z80 map
	localparam logic [1:0] CMD_PAGE = 2'b10;

	logic mem_cycle;
	logic cmd_rd;
	logic int_ack;

	// Refresh cycles also assert MREQ, so they are masked out
	assign mem_cycle = snd_rfsh_n_i & ~snd_mreq_n_i;
	assign cmd_rd = mem_cycle & ~snd_rd_n_i & (snd_addr_i[15:14] == CMD_PAGE);

	assign snd_rdata_o = cmd_rd ? sound_cmd_i : ironhorse_pkg::OPEN_BUS;

	// ==============================
	// Interrupt flag
	// ==============================

	// Z80 acknowledges a maskable interrupt with M1 and IORQ low together
	assign int_ack = ~snd_m1_n_i & ~snd_iorq_n_i;

	// Flag is set on the sound enable, so the Z80 sees it on its own clock
	// acknowledge wins if both land on the same edge
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			snd_int_n_o <= 1'b1;
		end else if (int_ack) begin
			snd_int_n_o <= 1'b1;
		end else if (cen_sound_i && sound_irq_req_i) begin
			snd_int_n_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: ironhorse_glue.f
hw/ironhorse_pkg.sv
hw/frac_cen.sv
hw/clock_enables.sv
hw/main_io_decode.sv
hw/sound_cpu_port.sv
hw/ironhorse_glue.sv
sim/ironhorse_glue_tb.sv

// File: sim/ironhorse_glue_tb.sv
// Iron Horse glue testbench driving a table of main bus accesses and checking strobes and latches
`timescale 1ns/1ps
`default_nettype none

module ironhorse_glue_tb;

	// ==============================
	// Constants and table storage
	// ==============================

	localparam int NUM_ROWS = 18;
	localparam int HOLD_CYCLES = 32;
	localparam int IRQ_LIMIT = 48;
	localparam int FRAC_PULSES = 50;
	localparam int FRAC_WINDOW = 786;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 2000;
	localparam logic [31:0] RNG_SEED = 32'h97e21394;
	localparam int KIND_READ = 0;
	localparam int KIND_PAL = 1;
	localparam int KIND_CMD = 2;
	localparam int KIND_IRQ = 3;

	logic clk_49m, sirq_clr, underclock_i;
	logic [15:0] main_addr_i, snd_addr_i;
	logic main_rw_i, main_ioc_n_i;
	logic [7:0] main_wdata_i;
	logic snd_mreq_n_i, snd_rfsh_n_i, snd_rd_n_i, snd_m1_n_i, snd_iorq_n_i;
	logic [23:0] dipsw_i;
	logic [1:0] coin_i, btn_start_i;
	logic btn_service_i;
	logic [3:0] p1_joystick_i, p2_joystick_i;
	logic [2:0] p1_buttons_i, p2_buttons_i;
	logic [7:0] main_rdata_o, snd_rdata_o;
	logic [2:0] pal_bank_o;
	logic snd_int_n_o, cen_e_o, cen_q_o, cen_sound_o;

	// One row per bus access, with the expected read byte or latch value
	logic [15:0] tab_addr [NUM_ROWS];
	logic tab_rw [NUM_ROWS];
	logic tab_ioc_n [NUM_ROWS];
	logic [7:0] tab_data [NUM_ROWS];
	int tab_kind [NUM_ROWS];
	logic [7:0] tab_expect [NUM_ROWS];
	int row_fill = 0;

	ironhorse_glue #(
		.FRAC_N(FRAC_PULSES),
		.FRAC_M(FRAC_WINDOW)
	) u_ironhorse_glue (
		.clk_49m(clk_49m), .sirq_clr(sirq_clr), .underclock_i(underclock_i),
		.main_addr_i(main_addr_i), .main_rw_i(main_rw_i), .main_ioc_n_i(main_ioc_n_i),
		.main_wdata_i(main_wdata_i), .snd_addr_i(snd_addr_i), .snd_mreq_n_i(snd_mreq_n_i),
		.snd_rfsh_n_i(snd_rfsh_n_i), .snd_rd_n_i(snd_rd_n_i), .snd_m1_n_i(snd_m1_n_i),
		.snd_iorq_n_i(snd_iorq_n_i), .dipsw_i(dipsw_i), .coin_i(coin_i),
		.btn_start_i(btn_start_i), .btn_service_i(btn_service_i),
		.p1_joystick_i(p1_joystick_i), .p2_joystick_i(p2_joystick_i),
		.p1_buttons_i(p1_buttons_i), .p2_buttons_i(p2_buttons_i),
		.main_rdata_o(main_rdata_o), .pal_bank_o(pal_bank_o), .snd_rdata_o(snd_rdata_o),
		.snd_int_n_o(snd_int_n_o), .cen_e_o(cen_e_o), .cen_q_o(cen_q_o),
		.cen_sound_o(cen_sound_o)
	);

	initial begin
		clk_49m = 1'b0;
		forever #10 clk_49m = ~clk_49m;
	end

	// ==============================
	// Helper tasks
	// ==============================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Run stopped on failure");
	endtask

	task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
			abort_run("Value mismatch");
		end
	endtask

	// Cycle t carries a pulse when the whole number of N/M steps grows by one
	function automatic logic frac_pulse_due(input int t);
		return ((t + 1) * FRAC_PULSES) / FRAC_WINDOW != (t * FRAC_PULSES) / FRAC_WINDOW;
	endfunction

	task automatic add_row(input logic [15:0] addr, input logic rw, input logic ioc_n,
			input logic [7:0] data, input int kind, input logic [7:0] exp);
		tab_addr[row_fill] = addr;
		tab_rw[row_fill] = rw;
		tab_ioc_n[row_fill] = ioc_n;
		tab_data[row_fill] = data;
		tab_kind[row_fill] = kind;
		tab_expect[row_fill] = exp;
		row_fill++;
	endtask

	// Player inputs and switches stay constant, so the table can hold final expected bytes
	task automatic build_table();
		logic [31:0] rnd;
		rnd = $urandom();
		dipsw_i <= rnd[23:0];
		add_row(16'h0100, 1'b1, 1'b0, 8'h00, KIND_READ, {4'hF, rnd[19:16]});
		add_row(16'h0200, 1'b1, 1'b0, 8'h00, KIND_READ, rnd[15:8]);
		add_row(16'h0300, 1'b1, 1'b0, 8'h00, KIND_READ, rnd[7:0]);
		rnd = $urandom();
		{p1_joystick_i, p2_joystick_i, p1_buttons_i, p2_buttons_i} <= rnd[13:0];
		{coin_i, btn_start_i, btn_service_i} <= rnd[18:14];
		add_row(16'h0301, 1'b1, 1'b0, 8'h00, KIND_READ, {1'b1, rnd[5], rnd[1:0], rnd[9:6]});
		add_row(16'h0302, 1'b1, 1'b0, 8'h00, KIND_READ, {1'b1, rnd[2], rnd[4:3], rnd[13:10]});
		add_row(16'h0303, 1'b1, 1'b0, 8'h00, KIND_READ, {3'b111, rnd[16:15], rnd[14], rnd[18:17]});
		// Only bits 10 to 8 and 1 to 0 take part, so this mirrors the P1 port
		add_row(16'h4B02, 1'b1, 1'b0, 8'h00, KIND_READ, {1'b1, rnd[2], rnd[4:3], rnd[13:10]});
		add_row(16'h0000, 1'b1, 1'b0, 8'h00, KIND_READ, 8'hFF);
		for (int r = 4; r < 8; r++) begin
			add_row({5'd0, r[2:0], 8'h00}, 1'b1, 1'b0, 8'h00, KIND_READ, 8'hFF);
		end
		add_row(16'h0300, 1'b1, 1'b1, 8'h00, KIND_READ, 8'hFF);
		rnd = $urandom();
		add_row(16'h0200, 1'b0, 1'b0, rnd[7:0], KIND_PAL, {5'd0, rnd[2:0]});
		add_row(16'h0200, 1'b0, 1'b0, rnd[7:0] ^ 8'h07, KIND_PAL, {5'd0, ~rnd[2:0]});
		add_row(16'h0000, 1'b0, 1'b0, rnd[15:8], KIND_CMD, rnd[15:8]);
		add_row(16'h0000, 1'b0, 1'b0, rnd[23:16], KIND_CMD, rnd[23:16]);
		add_row(16'h0100, 1'b0, 1'b0, 8'h00, KIND_IRQ, 8'h00);
	endtask

	task automatic apply_reset(input logic uclk);
		@(posedge clk_49m);
		sirq_clr <= 1'b1;
		underclock_i <= uclk;
		repeat (2) @(posedge clk_49m);
		sirq_clr <= 1'b0;
	endtask

	// Counter starts at zero, so sound lands on 0 mod 16, Q on 9 and E on 17 mod 32
	task automatic check_fixed_strobes();
		for (int t = 0; t < 128; t++) begin
			@(negedge clk_49m);
			if (t == 0) begin
				check_val("snd_int_n_o", 32'(snd_int_n_o), 32'd1);
				check_val("pal_bank_o", 32'(pal_bank_o), 32'd0);
			end
			check_val("cen_sound_o", 32'(cen_sound_o), 32'(t % 16 == 0));
			check_val("cen_q_o", 32'(cen_q_o), 32'(t % 32 == 9));
			check_val("cen_e_o", 32'(cen_e_o), 32'(t % 32 == 17));
		end
	endtask

	task automatic sound_read_check(input logic [7:0] exp);
		@(posedge clk_49m);
		snd_addr_i <= 16'h8000;
		snd_mreq_n_i <= 1'b0;
		snd_rd_n_i <= 1'b0;
		@(negedge clk_49m);
		check_val("snd_rdata_o", 32'(snd_rdata_o), 32'(exp));
		// Refresh masks the latch
		@(posedge clk_49m);
		snd_rfsh_n_i <= 1'b0;
		@(negedge clk_49m);
		check_val("snd_rdata_o", 32'(snd_rdata_o), 32'hFF);
		@(posedge clk_49m);
		snd_rfsh_n_i <= 1'b1;
		snd_rd_n_i <= 1'b1;
		@(negedge clk_49m);
		check_val("snd_rdata_o", 32'(snd_rdata_o), 32'hFF);
		@(posedge clk_49m);
		snd_mreq_n_i <= 1'b1;
	endtask

	task automatic run_row(input int idx);
		logic irq_seen;
		int waited;
		irq_seen = 1'b0;
		waited = 0;
		// No access before the region 1 write may raise the flag
		@(negedge clk_49m);
		check_val("snd_int_n_o", 32'(snd_int_n_o), 32'd1);
		@(posedge clk_49m);
		main_addr_i <= tab_addr[idx];
		main_rw_i <= tab_rw[idx];
		main_ioc_n_i <= tab_ioc_n[idx];
		main_wdata_i <= tab_data[idx];
		repeat (HOLD_CYCLES) begin
			@(negedge clk_49m);
			waited++;
			if (!snd_int_n_o) irq_seen = 1'b1;
		end
		if (tab_kind[idx] == KIND_READ)
			check_val("main_rdata_o", 32'(main_rdata_o), 32'(tab_expect[idx]));
		@(posedge clk_49m);
		main_ioc_n_i <= 1'b1;
		main_rw_i <= 1'b1;
		if (tab_kind[idx] == KIND_PAL) begin
			@(negedge clk_49m);
			check_val("pal_bank_o", 32'(pal_bank_o), 32'(tab_expect[idx]));
		end else if (tab_kind[idx] == KIND_CMD) begin
			sound_read_check(tab_expect[idx]);
		end else if (tab_kind[idx] == KIND_IRQ) begin
			while (!irq_seen && waited < IRQ_LIMIT) begin
				@(negedge clk_49m);
				waited++;
				if (!snd_int_n_o) irq_seen = 1'b1;
			end
			if (!irq_seen) abort_run("Sound interrupt did not assert within 48 cycles");
			// Flag must hold until the Z80 acknowledges it
			repeat (40) begin
				@(negedge clk_49m);
				check_val("snd_int_n_o", 32'(snd_int_n_o), 32'd0);
			end
			@(posedge clk_49m);
			snd_m1_n_i <= 1'b0;
			snd_iorq_n_i <= 1'b0;
			@(posedge clk_49m);
			snd_m1_n_i <= 1'b1;
			snd_iorq_n_i <= 1'b1;
			@(negedge clk_49m);
			check_val("snd_int_n_o", 32'(snd_int_n_o), 32'd1);
		end
	endtask

	// ==============================
	// Main sequence and watchdog
	// ==============================

	initial begin
		int pulses;
		pulses = 0;
		void'($urandom(RNG_SEED));
		sirq_clr <= 1'b1;
		underclock_i <= 1'b1;
		main_addr_i <= 16'h0000;
		main_rw_i <= 1'b1;
		main_ioc_n_i <= 1'b1;
		main_wdata_i <= 8'h00;
		snd_addr_i <= 16'h0000;
		{snd_mreq_n_i, snd_rfsh_n_i, snd_rd_n_i, snd_m1_n_i, snd_iorq_n_i} <= 5'b11111;
		build_table();
		// Fractional enable counted over one full window from reset
		apply_reset(1'b1);
		for (int t = 0; t < FRAC_WINDOW; t++) begin
			@(negedge clk_49m);
			if (cen_sound_o) pulses++;
			check_val("cen_sound_o", 32'(cen_sound_o), 32'(frac_pulse_due(t)));
		end
		check_val("cen_sound_o pulse count", 32'(pulses), 32'(FRAC_PULSES));
		apply_reset(1'b0);
		check_fixed_strobes();
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		repeat (4) @(posedge clk_49m);
		$display(">>> PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_49m);
		abort_run("Timeout, the test sequence did not finish in time");
	end

endmodule

`default_nettype wire
